//--- Bender.yml
package:
  name: mlp_inference

sources:
  - files:
      - rtl/mlpPkg.sv
      - rtl/neuronNode.sv
      - rtl/hiddenLayer.sv
      - rtl/outputLayer.sv
      - rtl/classSelect.sv
      - rtl/mlpInference.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mlpInference_tb.sv

//--- dv/mlpRefModel.svh
`ifndef MLP_REF_MODEL_SVH
`define MLP_REF_MODEL_SVH

// Scaled, clamped rectifier on the 16-bit wrapped sum
function automatic activation_t rectify(
	input int sum,
	output bit clamped,
	output bit wrapped
);
	logic [15:0] low;
	low = sum[15:0];	// Wrap to 16 bits
	wrapped = (sum > 32767) || (sum < -32768);
	clamped = low[13];
	if (clamped)
	begin
		return '0;
	end
	return low[13:6];
endfunction

function automatic hiddenVec_t hiddenModel(
	input featureVec_t f,
	output int clamps,
	output int wraps
);
	hiddenVec_t h;
	int sum;
	bit c;
	bit w;
	h = '0;
	clamps = 0;
	wraps = 0;
	for (int n = 0; n < NumHidden; n++)
	begin
		sum = int'(HiddenBias[n]);
		for (int i = 0; i < NumFeatures; i++)
		begin
			sum += int'(f[i*8 +: 8]) * int'(HiddenWeights[n][i]);	// Unsigned times signed
		end
		h[n*8 +: 8] = rectify(sum, c, w);
		clamps += c;
		wraps += w;
	end
	return h;
endfunction

function automatic scoreVec_t outputModel(
	input hiddenVec_t h,
	output int clamps,
	output int wraps
);
	scoreVec_t s;
	int sum;
	bit c;
	bit w;
	s = '0;
	clamps = 0;
	wraps = 0;
	for (int k = 0; k < NumClasses; k++)
	begin
		sum = int'(OutputBias[k]);
		for (int i = 0; i < NumHidden; i++)
		begin
			sum += int'(h[i*8 +: 8]) * int'(OutputWeights[k][i]);
		end
		s[k*8 +: 8] = rectify(sum, c, w);
		clamps += c;
		wraps += w;
	end
	return s;
endfunction

// Largest score, lowest index among equals
function automatic classIndex_t bestClass(
	input scoreVec_t s,
	output activation_t best,
	output bit tied
);
	classIndex_t idx;
	int hits;
	idx = '0;
	best = s[7:0];
	for (int k = 1; k < NumClasses; k++)
	begin
		if (s[k*8 +: 8] > best)
		begin
			idx = classIndex_t'(k);
			best = s[k*8 +: 8];
		end
	end
	hits = 0;
	for (int k = 0; k < NumClasses; k++)
	begin
		if (s[k*8 +: 8] == best)
		begin
			hits++;
		end
	end
	tied = (hits > 1);
	return idx;
endfunction

`endif

//--- dv/mlpInference_tb.sv
`timescale 1ns/100ps

module mlpInference_tb;

	import mlpPkg::*;

	`include "mlpRefModel.svh"

	localparam int ScoreDepth = 6;	// Edges from features to scores
	localparam int ClassDepth = 7;
	localparam int ResetCycles = 5;
	localparam int RandomCount = 250;
	localparam int TimeoutCycles = 450;

	logic clk;
	logic reset;
	featureVec_t features;
	scoreVec_t scores;
	classIndex_t classIndex;
	activation_t classScore;

	scoreVec_t expScores[$];
	classIndex_t expIndex[$];
	activation_t expScore[$];

	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int testStartErrors = 0;
	int cycleCount;
	int hiddenClamps = 0;
	int outputClamps = 0;
	int wrapCount = 0;
	int tieCount = 0;

	mlpInference i_mlpInference (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.classIndex(classIndex),
		.classScore(classScore)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Model result for each sampled vector, aligned to the DUT latency
	always @(posedge clk)
	begin : expectation
		hiddenVec_t hid;
		scoreVec_t sc;
		activation_t best;
		classIndex_t idx;
		int hc;
		int oc;
		int hw;
		int ow;
		bit tied;
		if (reset)
		begin
			expScores.delete();
			expIndex.delete();
			expScore.delete();
			repeat (ScoreDepth) expScores.push_back('0);	// Cleared pipeline
			repeat (ClassDepth)
			begin
				expIndex.push_back('0);
				expScore.push_back('0);
			end
		end
		else
		begin
			hid = hiddenModel(features, hc, hw);
			sc = outputModel(hid, oc, ow);
			idx = bestClass(sc, best, tied);
			hiddenClamps += hc;
			outputClamps += oc;
			wrapCount += hw + ow;
			if (tied)
			begin
				tieCount++;
			end
			expScores.push_back(sc);
			expIndex.push_back(idx);
			expScore.push_back(best);
			if (expScores.size() > ScoreDepth)
			begin
				void'(expScores.pop_front());
			end
			if (expIndex.size() > ClassDepth)
			begin
				void'(expIndex.pop_front());
				void'(expScore.pop_front());
			end
		end
	end

	// Outputs are stable mid-cycle
	always @(negedge clk)
	begin
		if (expScores.size() == ScoreDepth)
		begin
			assert (scores === expScores[0])
			else
			begin
				$display("** Error: scores expected %h got %h at %0t",
					expScores[0], scores, $time);
				errorCount++;
			end
		end
		if (expIndex.size() == ClassDepth)
		begin
			assert (classIndex === expIndex[0])
			else
			begin
				$display("** Error: classIndex expected %h got %h at %0t",
					expIndex[0], classIndex, $time);
				errorCount++;
			end
			assert (classScore === expScore[0])
			else
			begin
				$display("** Error: classScore expected %h got %h at %0t",
					expScore[0], classScore, $time);
				errorCount++;
			end
		end
	end

	task automatic applyVector(input featureVec_t v);
		@(posedge clk);
		#1;
		features = v;
	endtask

	task automatic drainPipeline();
		repeat (ClassDepth) applyVector('0);
	endtask

	function automatic featureVec_t randomVector(input int lo, input int hi);
		featureVec_t v;
		for (int i = 0; i < NumFeatures; i++)
		begin
			v[i*8 +: 8] = 8'($urandom_range(hi, lo));
		end
		return v;
	endfunction

	// Full scale on every feature whose weight has the chosen sign
	function automatic featureVec_t signVector(input int n, input bit positive);
		featureVec_t v;
		v = '0;
		for (int i = 0; i < NumFeatures; i++)
		begin
			if ((HiddenWeights[n][i] > 0) == positive)
			begin
				v[i*8 +: 8] = 8'hFF;
			end
		end
		return v;
	endfunction

	task automatic clearTallies();
		hiddenClamps = 0;
		outputClamps = 0;
		wrapCount = 0;
		tieCount = 0;
	endtask

	task automatic requireTally(input int count, input string what);
		if (count == 0)
		begin
			$display("Model never produced %s in this test", what);
			errorCount++;
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errorCount == testStartErrors)
		begin
			$display("Test %s: passed", name);
		end
		else
		begin
			$display("Test %s: failed, %0d errors", name, errorCount - testStartErrors);
			failedTests++;
		end
		testStartErrors = errorCount;
	endtask

	initial
	begin
		void'($urandom(32'hb7bc8213));
		reset = 1'b1;
		features = '0;

		repeat (ResetCycles) applyVector(randomVector(0, 255));	// Ignored under reset
		reset = 1'b0;
		drainPipeline();
		endTest("reset clears");

		applyVector('0);	// Bias only
		applyVector('1);
		for (int f = 0; f < NumFeatures; f++)
		begin
			applyVector(featureVec_t'(8'hFF) << (f * ActWidth));
		end
		drainPipeline();
		endTest("directed vectors");

		clearTallies();
		for (int n = 0; n < NumHidden; n++)
		begin
			applyVector(signVector(n, 1'b1));
			applyVector(signVector(n, 1'b0));
		end
		repeat (10) applyVector(randomVector(128, 255));
		@(posedge clk);
		#1;
		requireTally(hiddenClamps, "a clamped hidden neuron");
		requireTally(outputClamps, "a clamped output neuron");
		requireTally(wrapCount, "a sum wrapping past 16 bits");
		drainPipeline();
		endTest("clamp and wrap");

		clearTallies();
		repeat (20) applyVector(randomVector(0, 1));	// Small sums, often all scores zero
		@(posedge clk);
		#1;
		requireTally(tieCount, "tied top scores");
		drainPipeline();
		endTest("argmax tie-break");

		repeat (RandomCount) applyVector(randomVector(0, 255));
		drainPipeline();
		endTest("back-to-back random stream");

		repeat (20) applyVector(randomVector(0, 255));
		reset = 1'b1;
		repeat (ResetCycles) applyVector(randomVector(0, 255));
		reset = 1'b0;
		repeat (20) applyVector(randomVector(0, 255));
		drainPipeline();
		endTest("reset mid-stream");

		$display("Tests run %0d, tests failed %0d, errors %0d", testCount, failedTests, errorCount);
		if (errorCount == 0)
		begin
			$display("NO ERRORS");
		end
		else
		begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial
	begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run stopped after %0d cycles without finishing", cycleCount);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- rtl/classSelect.sv
`timescale 1ns/100ps

module classSelect (
	input logic clk,
	input logic reset,
	input mlpPkg::scoreVec_t scores,
	output mlpPkg::classIndex_t classIndex,
	output mlpPkg::activation_t classScore
);

	import mlpPkg::*;

	activation_t [NumClasses-1:0] score;	// Class 0 in the low byte
	classIndex_t bestIndex;
	activation_t bestScore;

	assign score = scores;

	// Later class replaces the best only when strictly greater
	always_comb
	begin
		bestIndex = '0;
		bestScore = score[0];
		for (int c = 1; c < NumClasses; c++)
		begin
			if (score[c] > bestScore)
			begin
				bestIndex = classIndex_t'(c);
				bestScore = score[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIndex <= '0;
			classScore <= '0;
		end
		else
		begin
			classIndex <= bestIndex;
			classScore <= bestScore;
		end
	end

endmodule

//--- rtl/hiddenLayer.sv
`timescale 1ns/100ps

module hiddenLayer (
	input logic clk,
	input logic reset,
	input mlpPkg::featureVec_t features,
	output mlpPkg::hiddenVec_t hiddenAct
);

	import mlpPkg::*;

	// Every hidden neuron sees all the features
	for (genvar n = 0; n < NumHidden; n++)
	begin : g_neuron
		neuronNode #(
			.FanIn(NumFeatures),
			.Weights(HiddenWeights[n]),
			.Bias(HiddenBias[n])
		) i_neuronNode (
			.clk(clk),
			.reset(reset),
			.act(features),
			.result(hiddenAct[n*ActWidth +: ActWidth])	// Neuron n to byte n
		);
	end

endmodule

//--- rtl/mlpInference.sv
`timescale 1ns/100ps

module mlpInference (
	input logic clk,
	input logic reset,
	input mlpPkg::featureVec_t features,
	output mlpPkg::scoreVec_t scores,
	output mlpPkg::classIndex_t classIndex,
	output mlpPkg::activation_t classScore
);

	import mlpPkg::*;

	hiddenVec_t hiddenAct;	// Valid 3 edges after features

	hiddenLayer i_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.features(features),
		.hiddenAct(hiddenAct)
	);

	// Scores 6 edges after features
	outputLayer i_outputLayer (
		.clk(clk),
		.reset(reset),
		.hiddenAct(hiddenAct),
		.scores(scores)
	);

	classSelect i_classSelect (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIndex(classIndex),
		.classScore(classScore)
	);

endmodule

//--- rtl/mlpPkg.sv
package mlpPkg;

	localparam int ActWidth = 8;
	localparam int WeightWidth = 8;
	localparam int AccWidth = 16;
	localparam int ClampBit = 13;	// Set bit forces a zero output
	localparam int ShiftLsb = 6;	// Output is sum[13:6]

	localparam int NumFeatures = 15;
	localparam int NumHidden = 8;
	localparam int NumClasses = 4;
	localparam int ClassWidth = $clog2(NumClasses);

	typedef logic [ActWidth-1:0] activation_t;
	typedef logic signed [WeightWidth-1:0] weight_t;
	typedef logic [AccWidth-1:0] accum_t;
	typedef logic [ClassWidth-1:0] classIndex_t;

	// Packed vectors, element 0 in the low byte
	typedef logic [NumFeatures*ActWidth-1:0] featureVec_t;
	typedef logic [NumHidden*ActWidth-1:0] hiddenVec_t;
	typedef logic [NumClasses*ActWidth-1:0] scoreVec_t;

	// Sign extension of a weight or bias into the sum width
	function automatic accum_t widen(weight_t w);
		accum_t wide;
		wide = {{(AccWidth-WeightWidth){w[WeightWidth-1]}}, w};
		return wide;
	endfunction

	// Row n holds the weights of hidden neuron n, column f the weight of feature f
	localparam weight_t [0:NumHidden-1][0:NumFeatures-1] HiddenWeights = '{
		'{ 12,  -8,  25,  31, -14,   7,   3, -22,  18,   9,  -5,  27, -11,  14,   6},
		'{-30,  44,   8, -12,  19,  26,  -7,  15,  -3,  21,  33, -18,   5,  -9,  11},
		'{  5,  17, -40,  22,  36,  -6,  13,  28, -19,   4,   8,  16,  30, -25,   2},
		'{ 48, -21,  15,   9, -33,  12,  27,  -4,   6,  38, -16,   7,  19,  23, -12},
		'{ -9,  14,  32, -27,  11,  41, -20,  18,  24, -13,  29,   3,  -6,  37,  15},
		'{ 21,   6, -17,  34,   8, -29,  45,  10,  -8,  16,   2,  39, -24,  12,  26},
		'{-50,  63, -42,  57, -38,  49, -61,  55, -47,  66, -35,  52, -58,  44, -40},
		'{ 18, -55,  74, -33, -27, -19, -57,   6,  14, -44,  -1,  -5,  99,  -7, -14}
	};

	localparam weight_t [0:NumHidden-1] HiddenBias = '{
		10,
		-4,
		20,
		-15,
		6,
		-8,
		0,
		-6
	};

	// Row c holds the weights of class c over the hidden activations
	localparam weight_t [0:NumClasses-1][0:NumHidden-1] OutputWeights = '{
		'{ 22, -10,  35,  14, -18,  27,   9,  -6},
		'{-15,  31,  12, -20,  40,   8, -11,  25},
		'{ 18,  24, -26,  33,   5, -14,  37,  16},
		'{ 40, -35,  20, -25,  30, -15,  10,  45}
	};

	localparam weight_t [0:NumClasses-1] OutputBias = '{
		12,
		-3,
		7,
		-20
	};

endpackage

//--- rtl/neuronNode.sv
`timescale 1ns/100ps

module neuronNode #(
	parameter int FanIn = 1,
	parameter mlpPkg::weight_t [0:FanIn-1] Weights = '0,
	parameter mlpPkg::weight_t Bias = '0
) (
	input logic clk,
	input logic reset,
	input logic [FanIn*mlpPkg::ActWidth-1:0] act,
	output mlpPkg::activation_t result
);

	import mlpPkg::*;

	activation_t [FanIn-1:0] actReg;	// Sampled inputs, input 0 in the low byte
	accum_t [FanIn-1:0] product;
	accum_t sumNext;
	accum_t sumReg;

	// Unsigned activation times signed weight, all wrapping in 16 bits
	always_comb
	begin
		sumNext = widen(Bias);
		for (int i = 0; i < FanIn; i++)
		begin
			product[i] = accum_t'(actReg[i]) * widen(Weights[i]);
			sumNext = sumNext + product[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= act;
			sumReg <= sumNext;
			if (sumReg[ClampBit])
			begin
				result <= '0;	// Clamp
			end
			else
			begin
				result <= sumReg[ClampBit:ShiftLsb];
			end
		end
	end

endmodule

//--- rtl/outputLayer.sv
`timescale 1ns/100ps

module outputLayer (
	input logic clk,
	input logic reset,
	input mlpPkg::hiddenVec_t hiddenAct,
	output mlpPkg::scoreVec_t scores
);

	import mlpPkg::*;

	for (genvar c = 0; c < NumClasses; c++)
	begin : g_neuron
		neuronNode #(
			.FanIn(NumHidden),
			.Weights(OutputWeights[c]),
			.Bias(OutputBias[c])
		) i_neuronNode (
			.clk(clk),
			.reset(reset),
			.act(hiddenAct),
			.result(scores[c*ActWidth +: ActWidth])	// Score of class c
		);
	end

endmodule

//--- vlog.f
+incdir+dv
rtl/mlpPkg.sv
rtl/neuronNode.sv
rtl/hiddenLayer.sv
rtl/outputLayer.sv
rtl/classSelect.sv
rtl/mlpInference.sv
dv/mlpInference_tb.sv
